/* Bender.yml */
package:
  name: core16

sources:
  - design/core_pkg.sv
  - design/core_fetch.sv
  - design/core_decode.sv
  - design/core_exec.sv
  - design/core_top.sv
  - target: simulation
    files:
      - bench/core_props.sv
      - bench/core_tb.sv

/* bench/core_props.sv */
`timescale 1ns/1ps
/*
 * bus and halt properties of the core top
 */
module core_props (
  input logic            clk,
  input logic            rst,
  input logic            inta_i,
  input core_pkg::addr_t adr_i,
  input logic            we_i,
  input core_pkg::word_t wdat_i,
  input logic            mem_op_i,
  input logic            block_i,
  input logic            halted_i
);

  // number of failed properties so far
  int unsigned error_count = 0;

  // acknowledge lasts a single cycle
  inta_pulse: assert property (@(posedge clk) disable iff (rst)
    inta_i |=> !inta_i)
    else begin
      $error("interrupt acknowledge held for more than one cycle");
      error_count++;
    end

  // blocked cycle keeps the port outputs
  bus_hold: assert property (@(posedge clk) disable iff (rst)
    block_i |=> $stable(adr_i) && $stable(we_i) && $stable(wdat_i))
    else begin
      $error("bus outputs changed while the port was blocked");
      error_count++;
    end

  // no memory traffic from a halted core
  halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halted_i |-> !mem_op_i)
    else begin
      $error("memory operation requested while halted");
      error_count++;
    end

endmodule

/* bench/core_tb.sv */
`timescale 1ns/1ps
/*
 * testbench for the small 16-bit core
 * memory model with random back-pressure, ISA reference model and an
 * in-order check of every completed store
 */
module core_tb;
  import core_pkg::*;

  localparam addr_t RESET_VECTOR = 16'h0004;
  localparam addr_t IRQ_VECTOR   = 16'h0020;
  localparam int    SEED         = 46056;

  logic  clk;
  logic  rst;
  logic  intr;
  logic  inta;
  addr_t adr;
  word_t dat_rd;
  word_t dat_wr;
  logic  we;
  logic  mem_op;
  logic  block;
  addr_t pc;

  // program image, copied into the memory while reset is high
  word_t image [64];
  word_t mem [64];
  word_t exp_adr [$];
  word_t exp_dat [$];
  int    store_idx;
  int    irq_store_count;
  int    block_pct;
  int    cursor;
  bit    seen;
  string test_name;

  core_top #(
    .RESET_VECTOR (RESET_VECTOR),
    .IRQ_VECTOR   (IRQ_VECTOR)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .intr_i   (intr),
    .inta_o   (inta),
    .adr_o    (adr),
    .dat_i    (dat_rd),
    .dat_o    (dat_wr),
    .we_o     (we),
    .mem_op_o (mem_op),
    .block_i  (block),
    .pc_o     (pc)
  );

  // halt seen from the exec FSM, independent of the top's halted register
  bind core_top core_props u_props (
    .clk      (clk),
    .rst      (rst),
    .inta_i   (inta_o),
    .adr_i    (adr_o),
    .we_i     (we_o),
    .wdat_i   (dat_o),
    .mem_op_i (mem_op_o),
    .block_i  (block_i),
    .halted_i (u_exec.state_q == core_pkg::EX_HALTED)
  );

  always #4 clk = ~clk;

  // reads are combinational, writes land on a completed store
  assign dat_rd = mem[adr[5:0]];

  always @(posedge clk) begin
    if (rst) begin
      mem <= image;
    end else if (mem_op && we && !block) begin
      mem[adr[5:0]] <= dat_wr;
    end
  end

  // random back-pressure on the memory port
  initial begin
    block = 1'b0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk);
      block <= ($urandom % 100) < block_pct;
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
    stop_run($sformatf("[ERROR] %s: %s expected %h actual %h",
                       test_name, what, expected, actual));
  endtask

  // bound bus and halt properties
  always @(posedge clk) begin
    assert (dut.u_props.error_count == 0)
      else stop_run($sformatf("%s: a bus or halt property of the core failed", test_name));
  end

  // every completed store against the model, in order
  always @(posedge clk) begin
    if (rst) begin
      store_idx <= 0;
    end else if (mem_op && we && !block) begin
      assert (store_idx < exp_adr.size())
        else stop_run($sformatf("%s: store of %h to %h was not expected",
                                test_name, dat_wr, adr));
      assert (adr == exp_adr[store_idx])
        else report_mismatch($sformatf("store %0d address", store_idx),
                             exp_adr[store_idx], adr);
      assert (dat_wr == exp_dat[store_idx])
        else report_mismatch($sformatf("store %0d data", store_idx),
                             exp_dat[store_idx], dat_wr);
      store_idx <= store_idx + 1;
    end
  end

  // ISA model of a program run, fills the expected store list
  function automatic void predict(input bit irq);
    word_t m [64];
    word_t r [4];
    addr_t p;
    word_t w;
    word_t imm;
    logic  zf;
    logic  ie;
    int    rd;
    int    rs;
    m = image;
    r = '{default: '0};
    p = RESET_VECTOR;
    zf = 1'b0;
    ie = 1'b0;
    irq_store_count = -1;
    exp_adr.delete();
    exp_dat.delete();
    for (int n = 0; n < 400; n++) begin
      w = m[p[5:0]];
      rd = w[11:10];
      rs = w[9:8];
      imm = {{8{w[7]}}, w[7:0]};
      p = p + 16'd1;
      case (w[15:12])
        OP_LI: r[rd] = imm;
        OP_ADD: begin
          r[rd] = r[rd] + r[rs];
          zf = r[rd] == '0;
        end
        OP_SUB: begin
          r[rd] = r[rd] - r[rs];
          zf = r[rd] == '0;
        end
        OP_LD: r[rd] = m[r[rs][5:0]];
        OP_ST: begin
          m[r[rs][5:0]] = r[rd];
          exp_adr.push_back(r[rs]);
          exp_dat.push_back(r[rd]);
        end
        // relative to the jump's own address
        OP_JMP: p = p - 16'd1 + imm;
        OP_JZ: begin
          if (zf) begin
            p = p - 16'd1 + imm;
          end
        end
        OP_EI: ie = 1'b1;
        OP_DI: ie = 1'b0;
        OP_HLT: begin
          if (!(irq && ie)) begin
            break;
          end
          ie = 1'b0;
          p = IRQ_VECTOR;
          irq_store_count = exp_adr.size();
        end
        default: begin
        end
      endcase
    end
  endfunction

  task automatic emit(input opcode_e op, input int rd, input int rs, input int imm);
    image[cursor] = {op, rd[1:0], rs[1:0], imm[7:0]};
    cursor = cursor + 1;
  endtask

  // unused words decode as nop and differ per address
  task automatic clear_image();
    for (int i = 0; i < 64; i++) begin
      image[i] = 16'hC000 + 16'(i * 37);
    end
    cursor = RESET_VECTOR;
  endtask

  task automatic build_arith();
    clear_image();
    emit(OP_LI, 0, 0, 5);
    emit(OP_LI, 1, 0, -3);
    emit(OP_ADD, 0, 1, 0);
    emit(OP_LI, 2, 0, 8'h30);
    emit(OP_ST, 0, 2, 0);
    emit(OP_SUB, 1, 0, 0);
    emit(OP_LI, 3, 0, 8'h31);
    emit(OP_ST, 1, 3, 0);
    emit(OP_LI, 2, 0, 8'h3A);
    emit(OP_LD, 0, 2, 0);
    emit(OP_ADD, 0, 0, 0);
    emit(OP_ST, 0, 3, 0);
    // read back what was just stored
    emit(OP_LD, 1, 3, 0);
    emit(OP_SUB, 1, 0, 0);
    emit(OP_LI, 2, 0, 8'h32);
    emit(OP_ST, 1, 2, 0);
    emit(OP_NOP, 0, 0, 0);
    emit(OP_HLT, 0, 0, 0);
  endtask

  task automatic build_branch();
    clear_image();
    emit(OP_LI, 0, 0, 7);
    emit(OP_LI, 1, 0, 7);
    emit(OP_LI, 2, 0, 8'h33);
    emit(OP_SUB, 0, 1, 0);
    emit(OP_JZ, 0, 0, 3);
    emit(OP_ST, 1, 2, 0);
    emit(OP_JMP, 0, 0, 0);
    emit(OP_LI, 3, 0, 8'h40);
    emit(OP_ST, 3, 2, 0);
    emit(OP_ADD, 3, 1, 0);
    emit(OP_JZ, 0, 0, 2);
    emit(OP_ST, 3, 2, 0);
    emit(OP_LI, 0, 0, 3);
    emit(OP_LI, 1, 0, 1);
    // countdown loop, stores 2, 1, 0
    emit(OP_SUB, 0, 1, 0);
    emit(OP_ST, 0, 2, 0);
    emit(OP_JZ, 0, 0, 2);
    emit(OP_JMP, 0, 0, -3);
    emit(OP_JMP, 0, 0, 2);
    emit(OP_ST, 1, 2, 0);
    emit(OP_HLT, 0, 0, 0);
  endtask

  task automatic build_irq(input bit enable);
    clear_image();
    emit(OP_LI, 0, 0, 8'h11);
    emit(OP_LI, 1, 0, 8'h34);
    emit(OP_ST, 0, 1, 0);
    emit(enable ? OP_EI : OP_DI, 0, 0, 0);
    emit(OP_HLT, 0, 0, 0);
    emit(OP_ST, 1, 1, 0);
    // handler stores its marker word
    cursor = IRQ_VECTOR;
    emit(OP_LI, 2, 0, 8'h5A);
    emit(OP_LI, 3, 0, 8'h3F);
    emit(OP_ST, 2, 3, 0);
    emit(OP_HLT, 0, 0, 0);
  endtask

  task automatic start_test(input string name, input int pct);
    test_name = name;
    block_pct = pct;
    rst <= 1'b1;
    intr <= 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_stores(input int n);
    int cycles;
    cycles = 0;
    while (store_idx < n) begin
      @(posedge clk);
      cycles++;
      assert (cycles <= 3000)
        else stop_run($sformatf("%s: timed out waiting for store %0d", test_name, store_idx));
    end
  endtask

  // a long idle bus means the core sits in halt
  task automatic wait_halted();
    int cycles;
    int idle;
    cycles = 0;
    idle = 0;
    while (idle < 12) begin
      @(posedge clk);
      idle = mem_op ? 0 : idle + 1;
      cycles++;
      assert (cycles <= 3000)
        else stop_run($sformatf("%s: core never went quiet after its stores", test_name));
    end
  endtask

  task automatic wait_inta(input int limit, output bit hit);
    int cycles;
    cycles = 0;
    hit = 1'b0;
    while (!hit && cycles < limit) begin
      @(posedge clk);
      hit = inta;
      cycles++;
    end
  endtask

  task automatic run_to_halt(input string name, input int pct);
    predict(1'b0);
    start_test(name, pct);
    wait_stores(exp_adr.size());
    wait_halted();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    intr = 1'b0;
    block_pct = 0;

    build_arith();
    run_to_halt("arith", 0);
    build_branch();
    run_to_halt("branch", 0);

    build_arith();
    run_to_halt("backpressure_arith", 40);
    build_branch();
    run_to_halt("backpressure_branch", 40);

    build_irq(1'b1);
    predict(1'b1);
    start_test("halt_irq_on", 30);
    wait_stores(irq_store_count);
    wait_halted();
    intr <= 1'b1;
    wait_inta(500, seen);
    assert (seen)
      else stop_run("halt_irq_on: no interrupt acknowledge after intr_i was raised");
    intr <= 1'b0;
    // fetch restarts at the interrupt vector right after the acknowledge
    @(posedge clk);
    assert (pc == IRQ_VECTOR)
      else report_mismatch("pc after acknowledge", IRQ_VECTOR, pc);
    wait_stores(exp_adr.size());
    wait_halted();

    // an expected timeout, nothing may wake the core
    build_irq(1'b0);
    predict(1'b1);
    start_test("halt_irq_off", 30);
    wait_stores(exp_adr.size());
    wait_halted();
    intr <= 1'b1;
    wait_inta(200, seen);
    assert (!seen)
      else stop_run("halt_irq_off: interrupt taken with interrupts disabled");
    intr <= 1'b0;

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* design/core_decode.sv */
`timescale 1ns/1ps
/*
 * decode stage
 * splits a fetched word into an exec bundle and issues ld / st as an
 * address step followed by a data step
 */
module core_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stall_i,
  input  logic                    flush_i,
  input  core_pkg::fetch_bundle_t fetch_i,
  input  logic                    fetch_valid_i,
  output logic                    take_o,
  input  logic                    busy_i,
  output core_pkg::exec_bundle_t  bundle_o,
  output logic                    valid_o
);
  import core_pkg::*;

  exec_bundle_t bundle_q;
  exec_bundle_t dec;
  logic         valid_q;
  logic         advance;
  logic         split;
  logic [3:0]   code;

  // field split of the fetched word
  always_comb begin
    code    = fetch_i.instr[15:12];
    dec.rd  = fetch_i.instr[11:10];
    dec.rs  = fetch_i.instr[9:8];
    dec.imm = {{8{fetch_i.instr[7]}}, fetch_i.instr[7:0]};
    dec.pc  = fetch_i.pc;
    // unused codes run as nop
    if (code <= OP_HLT) begin
      dec.op = opcode_e'(code);
    end else begin
      dec.op = OP_NOP;
    end
    // memory ops start with the address step
    dec.last = !(dec.op inside {OP_LD, OP_ST});
  end

  // exec takes the held step this cycle
  assign advance = valid_q && !busy_i && !stall_i;

  // address step out, data step still to come from the same word
  assign split = (bundle_q.op inside {OP_LD, OP_ST}) && !bundle_q.last;

  assign take_o = fetch_valid_i && !flush_i && !stall_i &&
                  (!valid_q || (advance && !split));

  assign bundle_o = bundle_q;
  assign valid_o  = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (take_o) begin
      valid_q <= 1'b1;
    end else if (advance && !split) begin
      valid_q <= 1'b0;
    end
  end

  // second step reuses the fields with the last bit set
  always_ff @(posedge clk) begin
    if (take_o) begin
      bundle_q <= dec;
    end else if (advance && split) begin
      bundle_q.last <= 1'b1;
    end
  end

endmodule

/* design/core_exec.sv */
`timescale 1ns/1ps
/*
 * execute stage
 * register file, adder, zero and interrupt-enable flags, data access
 * on the shared port and branch / interrupt redirect
 */
module core_exec #(
  parameter core_pkg::addr_t RESET_VECTOR = 16'h0000,
  parameter core_pkg::addr_t IRQ_VECTOR   = 16'h0020
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  core_pkg::exec_bundle_t bundle_i,
  input  logic                   valid_i,
  output logic                   busy_o,
  output logic                   mem_o,
  output core_pkg::addr_t        adr_o,
  output core_pkg::word_t        dat_o,
  output logic                   we_o,
  input  core_pkg::word_t        dat_i,
  input  logic                   grant_i,
  output logic                   redirect_o,
  output core_pkg::addr_t        target_o,
  output logic                   halt_o,
  input  logic                   wake_i,
  output logic                   ifl_o
);
  import core_pkg::*;

  word_t       regs [4];
  exec_state_e state_q;
  logic        zf_q;
  logic        ifl_q;
  addr_t       addr_q;
  reg_idx_t    mem_reg_q;
  logic        store_q;
  logic        accept;
  logic        taken;
  word_t       src_val;
  word_t       dst_val;
  word_t       alu;

  assign accept  = (state_q == EX_RUN) && valid_i && !stall_i;
  assign src_val = regs[bundle_i.rs];
  assign dst_val = regs[bundle_i.rd];
  assign alu     = (bundle_i.op == OP_SUB) ? dst_val - src_val : dst_val + src_val;
  assign taken   = accept && (bundle_i.op == OP_JMP || (bundle_i.op == OP_JZ && zf_q));

  assign busy_o = state_q != EX_RUN;
  assign mem_o  = state_q == EX_MEM;
  assign we_o   = (state_q == EX_MEM) && store_q;
  assign adr_o  = addr_q;
  assign dat_o  = we_o ? regs[mem_reg_q] : '0;
  assign halt_o = accept && bundle_i.op == OP_HLT;
  assign ifl_o  = ifl_q;

  // jumps are relative to the jump's own address
  always_comb begin
    redirect_o = taken;
    target_o   = bundle_i.pc + bundle_i.imm;
    case (state_q)
      EX_IDLE: begin
        redirect_o = !stall_i;
        target_o   = RESET_VECTOR;
      end
      EX_HALTED: begin
        redirect_o = wake_i;
        target_o   = IRQ_VECTOR;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= EX_IDLE;
      zf_q    <= 1'b0;
      ifl_q   <= 1'b0;
    end else begin
      case (state_q)
        EX_IDLE: begin
          if (!stall_i) begin
            state_q <= EX_RUN;
          end
        end
        EX_RUN: begin
          if (accept) begin
            case (bundle_i.op)
              OP_ADD, OP_SUB: zf_q <= (alu == '0);
              OP_EI: ifl_q <= 1'b1;
              OP_DI: ifl_q <= 1'b0;
              OP_LD, OP_ST: begin
                if (bundle_i.last) begin
                  state_q <= EX_MEM;
                end
              end
              OP_HLT: state_q <= EX_HALTED;
              default: begin
              end
            endcase
          end
        end
        EX_MEM: begin
          if (grant_i) begin
            state_q <= EX_RUN;
          end
        end
        default: begin
          // interrupt entry masks further interrupts
          if (wake_i) begin
            ifl_q   <= 1'b0;
            state_q <= EX_RUN;
          end
        end
      endcase
    end
  end

  // register file and data access operands
  always_ff @(posedge clk) begin
    if (accept) begin
      case (bundle_i.op)
        OP_LI: regs[bundle_i.rd] <= bundle_i.imm;
        OP_ADD, OP_SUB: regs[bundle_i.rd] <= alu;
        OP_LD, OP_ST: begin
          if (!bundle_i.last) begin
            addr_q <= src_val;
          end else begin
            mem_reg_q <= bundle_i.rd;
            store_q   <= bundle_i.op == OP_ST;
          end
        end
        default: begin
        end
      endcase
    end else if (state_q == EX_MEM && grant_i && !store_q) begin
      regs[mem_reg_q] <= dat_i;
    end
  end

endmodule

/* design/core_fetch.sv */
`timescale 1ns/1ps
/*
 * fetch stage
 * keeps the instruction pointer and a one-entry instruction buffer,
 * filled over the shared memory port
 */
module core_fetch #(
  parameter core_pkg::addr_t RESET_VECTOR = 16'h0000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stall_i,
  input  logic                    redirect_i,
  input  core_pkg::addr_t         target_i,
  input  logic                    grant_i,
  input  core_pkg::word_t         dat_i,
  output logic                    req_o,
  output core_pkg::addr_t         adr_o,
  input  logic                    take_i,
  output core_pkg::fetch_bundle_t bundle_o,
  output logic                    valid_o,
  output core_pkg::addr_t         pc_o
);
  import core_pkg::*;

  addr_t         ip_q;
  logic          valid_q;
  fetch_bundle_t buf_q;
  logic          load;

  // refill when empty or when decode drains the entry this cycle
  // nothing is requested while the pointer is being redirected
  assign req_o = (!valid_q || take_i) && !redirect_i;
  assign load  = grant_i && !stall_i && !redirect_i;

  assign adr_o    = ip_q;
  assign pc_o     = ip_q;
  assign bundle_o = buf_q;
  assign valid_o  = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= RESET_VECTOR;
      valid_q <= 1'b0;
    end else if (redirect_i) begin
      // jump, interrupt entry or reset start, drop the buffered word
      ip_q    <= target_i;
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      if (load) begin
        ip_q    <= ip_q + 16'd1;
        valid_q <= 1'b1;
      end else if (take_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // word and its address, qualified by valid_q
  always_ff @(posedge clk) begin
    if (load) begin
      buf_q.instr <= dat_i;
      buf_q.pc    <= ip_q;
    end
  end

endmodule

/* design/core_pkg.sv */
/*
 * core package
 * shared word types, opcode encoding, stage bundles and exec FSM states
 * of the small 16-bit core
 */
package core_pkg;

  // data word, also the width of every register
  typedef logic [15:0] word_t;

  // word address on the shared memory port
  typedef logic [15:0] addr_t;

  // one of the four general registers
  typedef logic [1:0] reg_idx_t;

  // instruction word layout
  //   [15:12] opcode
  //   [11:10] rd
  //   [9:8]   rs
  //   [7:0]   immediate, sign extended
  typedef enum logic [3:0] {
    // no operation
    OP_NOP = 4'h0,
    // rd = imm
    OP_LI  = 4'h1,
    // rd = rd + rs, updates zf
    OP_ADD = 4'h2,
    // rd = rd - rs, updates zf
    OP_SUB = 4'h3,
    // rd = mem[rs]
    OP_LD  = 4'h4,
    // mem[rs] = rd
    OP_ST  = 4'h5,
    // jump to own address + imm
    OP_JMP = 4'h6,
    // same, only when zf is set
    OP_JZ  = 4'h7,
    // interrupt enable flag on / off
    OP_EI  = 4'h8,
    OP_DI  = 4'h9,
    // stop until an enabled interrupt
    OP_HLT = 4'hA
  } opcode_e;

  // fetch to decode
  typedef struct packed {
    word_t instr;
    addr_t pc;
  } fetch_bundle_t;

  // decode to exec, one step of an instruction
  typedef struct packed {
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs;
    word_t    imm;
    addr_t    pc;
    // low only on the address step of ld / st
    logic     last;
  } exec_bundle_t;

  // exec FSM
  // idle   : out of reset, sends the reset redirect
  // run    : takes one step per cycle
  // mem    : data access on the shared port
  // halted : waits for wake
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_RUN,
    EX_MEM,
    EX_HALTED
  } exec_state_e;

endpackage

/* design/core_top.sv */
`timescale 1ns/1ps
/*
 * core top
 * wires fetch, decode and exec, arbitrates the shared memory port and
 * holds the halt and interrupt wake logic
 */
module core_top #(
  parameter core_pkg::addr_t RESET_VECTOR = 16'h0000,
  parameter core_pkg::addr_t IRQ_VECTOR   = 16'h0020
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            intr_i,
  output logic            inta_o,
  output core_pkg::addr_t adr_o,
  input  core_pkg::word_t dat_i,
  output core_pkg::word_t dat_o,
  output logic            we_o,
  output logic            mem_op_o,
  input  logic            block_i,
  output core_pkg::addr_t pc_o
);
  import core_pkg::*;

  fetch_bundle_t fetch_bundle;
  logic          fetch_valid;
  logic          decode_take;
  logic          fetch_req;
  logic          fetch_grant;
  addr_t         fetch_adr;
  exec_bundle_t  exec_bundle;
  logic          exec_valid;
  logic          exec_busy;
  logic          exec_mem;
  logic          exec_grant;
  addr_t         exec_adr;
  logic          redirect;
  addr_t         target;
  logic          exec_halt;
  logic          ifl;
  logic          halted_q;
  logic          stall;
  logic          wake;

  assign stall = block_i | halted_q;

  // enabled interrupt ends the halt, bus must be free to redirect
  assign wake   = halted_q && intr_i && ifl && !block_i;
  assign inta_o = wake;

  // exec owns the port during its data step
  assign exec_grant  = exec_mem && !stall;
  assign fetch_grant = fetch_req && !exec_mem && !stall;
  assign adr_o       = exec_mem ? exec_adr : fetch_adr;
  assign mem_op_o    = (exec_mem || fetch_req) && !halted_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (wake) begin
      halted_q <= 1'b0;
    end else if (exec_halt) begin
      halted_q <= 1'b1;
    end
  end

  core_fetch #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall),
    .redirect_i (redirect),
    .target_i   (target),
    .grant_i    (fetch_grant),
    .dat_i      (dat_i),
    .req_o      (fetch_req),
    .adr_o      (fetch_adr),
    .take_i     (decode_take),
    .bundle_o   (fetch_bundle),
    .valid_o    (fetch_valid),
    .pc_o       (pc_o)
  );

  core_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall),
    .flush_i       (redirect),
    .fetch_i       (fetch_bundle),
    .fetch_valid_i (fetch_valid),
    .take_o        (decode_take),
    .busy_i        (exec_busy),
    .bundle_o      (exec_bundle),
    .valid_o       (exec_valid)
  );

  core_exec #(
    .RESET_VECTOR (RESET_VECTOR),
    .IRQ_VECTOR   (IRQ_VECTOR)
  ) u_exec (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall),
    .bundle_i   (exec_bundle),
    .valid_i    (exec_valid),
    .busy_o     (exec_busy),
    .mem_o      (exec_mem),
    .adr_o      (exec_adr),
    .dat_o      (dat_o),
    .we_o       (we_o),
    .dat_i      (dat_i),
    .grant_i    (exec_grant),
    .redirect_o (redirect),
    .target_o   (target),
    .halt_o     (exec_halt),
    .wake_i     (wake),
    .ifl_o      (ifl)
  );

endmodule

/* sim.f */
design/core_pkg.sv
design/core_fetch.sv
design/core_decode.sv
design/core_exec.sv
design/core_top.sv
bench/core_props.sv
bench/core_tb.sv
